// File: bench/vpu_clkgen.sv
// Clock starts low at time zero; reset is released 1 ns after the last reset cycle's rising edge
`default_nettype none

module vpu_clkgen #(
  parameter int unsigned HalfPeriod  = 2,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // Release off the edge, like every other input
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule : vpu_clkgen

`default_nettype wire

// File: bench/vpu_tb.sv
// Reads bench/vpu_testdata.txt relative to the run directory; holds at most MaxRecords instructions
`default_nettype none

module vpu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NrFields   = 6;
  localparam int unsigned MaxRecords = 64;
  localparam int unsigned DriveDelay = 1;
  localparam int unsigned BurstEvery = 6;
  localparam logic [31:0] Seed       = 32'hd71463fe;
  localparam logic [31:0] EndMarker  = 32'hffff_ffff;

  logic               clk;
  logic               arst_n;
  vpu_pkg::vpu_req_t  req;
  logic               req_valid;
  logic               req_credit;
  vpu_pkg::vpu_resp_t resp;
  logic               resp_valid;
  logic               resp_credit;

  logic [31:0]        tdata [MaxRecords*NrFields];
  vpu_pkg::vpu_req_t  reqs  [MaxRecords];
  vpu_pkg::vpu_resp_t exps  [MaxRecords];
  vpu_pkg::vpu_resp_t exp_q [$];

  int nr_records   = 0;
  int req_credits  = vpu_pkg::QueueDepth;
  int reqs_sent    = 0;
  int credits_back = 0;
  int resp_seen    = 0;
  int granted      = 0;
  int cycle_count  = 0;
  int cycle_limit  = 0;

  vpu_clkgen i_clkgen (
    .clk_o    (clk    ),
    .arst_n_o (arst_n )
  );

  vpu_top dut0 (
    .clk_i         (clk         ),
    .arst_n_i      (arst_n      ),
    .req_i         (req         ),
    .req_valid_i   (req_valid   ),
    .req_credit_o  (req_credit  ),
    .resp_o        (resp        ),
    .resp_valid_o  (resp_valid  ),
    .resp_credit_i (resp_credit )
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_resp(input vpu_pkg::vpu_resp_t got, input vpu_pkg::vpu_resp_t exp,
                            input int idx);
    if (got !== exp) begin
      $display("Fail %0t: response %0d result %h, expected %h", $time, idx, got.result,
               exp.result);
      stop_with_failure();
    end
  endtask

  task automatic check_credits(input int returned, input int sent);
    if (returned != sent) begin
      $display("Fail %0t: %0d request credits returned for %0d requests", $time, returned, sent);
      stop_with_failure();
    end
  endtask

  // One record per line: op vd vs1 vs2 scalar expected
  task automatic load_testdata();
    int base;
    for (int i = 0; i < MaxRecords * NrFields; i++) begin
      tdata[i] = EndMarker;
    end
    $readmemh("bench/vpu_testdata.txt", tdata);
    while (nr_records < MaxRecords && tdata[nr_records * NrFields] != EndMarker) begin
      base = nr_records * NrFields;
      reqs[nr_records].op     = vpu_pkg::vpu_op_e'(tdata[base][3:0]);
      reqs[nr_records].vd     = vpu_pkg::vreg_idx_t'(tdata[base + 1]);
      reqs[nr_records].vs1    = vpu_pkg::vreg_idx_t'(tdata[base + 2]);
      reqs[nr_records].vs2    = vpu_pkg::vreg_idx_t'(tdata[base + 3]);
      reqs[nr_records].scalar = tdata[base + 4];
      exps[nr_records].result = tdata[base + 5];
      nr_records++;
    end
    if (nr_records == 0) begin
      $display("No instructions could be read from bench/vpu_testdata.txt");
      stop_with_failure();
    end
  endtask

  // Holds resp_credit high for n consecutive cycles
  task automatic grant_resp_credits(input int n);
    repeat (n) begin
      @(posedge clk);
      #DriveDelay;
      resp_credit = 1'b1;
      granted++;
    end
    @(posedge clk);
    #DriveDelay;
    resp_credit = 1'b0;
  endtask

  //////////////////////////////
  // Request side
  //////////////////////////////

  initial begin : drive_requests
    int idx;
    req       = '0;
    req_valid = 1'b0;
    idx       = 0;
    load_testdata();
    cycle_limit = nr_records * (vpu_pkg::ElemsPerLane + 8) + 100;
    @(posedge arst_n);
    while (idx < nr_records) begin
      @(posedge clk);
      #DriveDelay;
      if (req_credits > 0) begin
        req       = reqs[idx];
        req_valid = 1'b1;
        exp_q.push_back(exps[idx]);
        req_credits--;
        reqs_sent++;
        idx++;
      end else begin
        req_valid = 1'b0;
      end
    end
    @(posedge clk);
    #DriveDelay;
    req_valid = 1'b0;
    // A lost response ends in the timeout below
    while (resp_seen < nr_records) @(posedge clk);
    repeat (4) @(posedge clk);
    check_credits(credits_back, reqs_sent);
    $display("Simulation completed successfully");
    $finish;
  end

  //////////////////////////////
  // Response credits
  //////////////////////////////

  // Random gaps, with a periodic hold that lets the queue fill up
  initial begin : grant_credits
    int gap;
    resp_credit = 1'b0;
    void'($urandom(Seed));
    @(posedge arst_n);
    while (granted < nr_records) begin
      if (granted != 0 && granted % BurstEvery == 0) begin
        while (req_credits != 0 && reqs_sent < nr_records) @(posedge clk);
        gap = nr_records - granted;
        grant_resp_credits((gap < vpu_pkg::QueueDepth) ? gap : vpu_pkg::QueueDepth);
      end else begin
        gap = $urandom_range(5, 0);
        repeat (gap) @(posedge clk);
        grant_resp_credits(1);
      end
    end
  end

  //////////////////////////////
  // Monitor and timeout
  //////////////////////////////

  always @(negedge clk) begin
    if (arst_n) begin
      if (req_credit) begin
        if (credits_back >= reqs_sent) begin
          $display("Fail %0t: request credit returned with no request outstanding", $time);
          stop_with_failure();
        end else begin
          credits_back++;
          req_credits++;
        end
      end
      if (resp_valid) begin
        if (exp_q.size() == 0) begin
          $display("Fail %0t: response arrived with no request outstanding", $time);
          stop_with_failure();
        end else begin
          check_resp(resp, exp_q.pop_front(), resp_seen);
          resp_seen++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timed out after %0d cycles with %0d of %0d responses seen", cycle_count,
               resp_seen, nr_records);
      stop_with_failure();
    end
  end

endmodule : vpu_tb

`default_nettype wire

// File: bench/vpu_testdata.txt
// op vd vs1 vs2 scalar expected, all hex; op 0 vmv.v.x 1 vid 2 add 3 sub 4 and 5 or 6 xor 7 redsum 8 vmv.x.s
0 1 0 0 00000005 00000000
1 2 0 0 00000000 00000000
7 0 0 0 00000000 00000000
7 0 0 2 00000000 00000078
7 0 0 1 00000000 00000050
8 0 0 1 00000000 00000005
8 0 0 2 00000000 00000000
0 3 0 0 000000a5 00000000
2 4 1 2 00000000 00000000
7 0 0 4 00000000 000000c8
8 0 0 4 00000000 00000005
3 5 2 1 00000000 00000000
7 0 0 5 00000000 ffffffd8
8 0 0 5 00000000 00000005
4 6 3 2 00000000 00000000
7 0 0 6 00000000 00000028
5 7 3 2 00000000 00000000
7 0 0 7 00000000 00000aa0
6 6 3 2 00000000 00000000
7 0 0 6 00000000 00000a78
8 0 0 6 00000000 000000a5

// File: common/vpu_pkg.sv
// Sizes must stay powers of two, ElemsPerLane at least 2; host grants at most 2**CreditWidth-1 credits
`default_nettype none

package vpu_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 4;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned QueueDepth   = 4;

  // Derived widths
  localparam int unsigned QueuePtrWidth = $clog2(QueueDepth);
  localparam int unsigned QueueCntWidth = $clog2(QueueDepth + 1);
  localparam int unsigned CreditWidth   = 8;

  //////////////////////////////
  // Basic types
  //////////////////////////////

  typedef logic [ElemWidth-1:0]            elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]      vreg_idx_t;
  typedef logic [$clog2(ElemsPerLane)-1:0] row_idx_t;

  // Supported integer subset
  typedef enum logic [3:0] {
    OP_VMV_VX  = 4'd0,
    OP_VID     = 4'd1,
    OP_VADD    = 4'd2,
    OP_VSUB    = 4'd3,
    OP_VAND    = 4'd4,
    OP_VOR     = 4'd5,
    OP_VXOR    = 4'd6,
    OP_VREDSUM = 4'd7,
    OP_VMV_XS  = 4'd8
  } vpu_op_e;

  //////////////////////////////
  // Interface structs
  //////////////////////////////

  // Instruction as sent by the host core
  typedef struct packed {
    vpu_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } vpu_req_t;

  // Scalar result, zero for pure vector ops
  typedef struct packed {
    elem_t result;
  } vpu_resp_t;

  // One row of work, same for every lane
  typedef struct packed {
    vpu_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    row_idx_t  row;
    logic      valid;
    logic      last;
  } lane_cmd_t;

endpackage : vpu_pkg

`default_nettype wire

// File: lane/vpu_lane.sv
// Partial is meaningful only for OP_VREDSUM and OP_VMV_XS, after the row with last set
`default_nettype none

module vpu_lane #(
  parameter int unsigned LaneId = 0
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  vpu_pkg::lane_cmd_t cmd_i,
  output vpu_pkg::elem_t     partial_o
);

  vpu_pkg::elem_t vs1_data;
  vpu_pkg::elem_t vs2_data;
  vpu_pkg::elem_t alu_result;
  vpu_pkg::elem_t partial_base;
  vpu_pkg::elem_t partial_q;
  logic           wr_en;

  vpu_vrf i_vrf (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .rd_a_reg_i (cmd_i.vs1  ),
    .rd_b_reg_i (cmd_i.vs2  ),
    .rd_row_i   (cmd_i.row  ),
    .rd_a_o     (vs1_data   ),
    .rd_b_o     (vs2_data   ),
    .wr_en_i    (wr_en      ),
    .wr_reg_i   (cmd_i.vd   ),
    .wr_row_i   (cmd_i.row  ),
    .wr_data_i  (alu_result )
  );

  //////////////////////////////
  // Integer ALU
  //////////////////////////////

  always_comb begin
    unique case (cmd_i.op)
      vpu_pkg::OP_VADD:   alu_result = vs2_data + vs1_data;
      vpu_pkg::OP_VSUB:   alu_result = vs2_data - vs1_data;
      vpu_pkg::OP_VAND:   alu_result = vs2_data & vs1_data;
      vpu_pkg::OP_VOR:    alu_result = vs2_data | vs1_data;
      vpu_pkg::OP_VXOR:   alu_result = vs2_data ^ vs1_data;
      vpu_pkg::OP_VMV_VX: alu_result = cmd_i.scalar;
      // Global index of this lane's element in the row
      vpu_pkg::OP_VID: begin
        alu_result = vpu_pkg::elem_t'(cmd_i.row) * vpu_pkg::elem_t'(vpu_pkg::NrLanes)
                   + vpu_pkg::elem_t'(LaneId);
      end
      default:            alu_result = '0;
    endcase
  end

  // Scalar-producing ops leave the register file alone
  assign wr_en = cmd_i.valid &&
                 !(cmd_i.op inside {vpu_pkg::OP_VREDSUM, vpu_pkg::OP_VMV_XS});

  //////////////////////////////
  // Partial result
  //////////////////////////////

  // Row 0 starts a fresh partial
  assign partial_base = (cmd_i.row == '0) ? '0 : partial_q;

  always_ff @(posedge clk_i) begin
    if (cmd_i.valid) begin
      unique case (cmd_i.op)
        vpu_pkg::OP_VREDSUM: partial_q <= partial_base + vs2_data;
        vpu_pkg::OP_VMV_XS: begin
          if (cmd_i.row == '0) begin
            partial_q <= vs2_data;
          end
        end
        default:             partial_q <= partial_base;
      endcase
    end
  end

  assign partial_o = partial_q;

endmodule : vpu_lane

`default_nettype wire

// File: lane/vpu_vrf.sv
// Reads are combinational, so data is available in the same cycle as the row command
`default_nettype none

module vpu_vrf (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  vpu_pkg::vreg_idx_t  rd_a_reg_i,
  input  vpu_pkg::vreg_idx_t  rd_b_reg_i,
  input  vpu_pkg::row_idx_t   rd_row_i,
  output vpu_pkg::elem_t      rd_a_o,
  output vpu_pkg::elem_t      rd_b_o,
  input  logic                wr_en_i,
  input  vpu_pkg::vreg_idx_t  wr_reg_i,
  input  vpu_pkg::row_idx_t   wr_row_i,
  input  vpu_pkg::elem_t      wr_data_i
);

  // This lane's rows of every vector register
  vpu_pkg::elem_t regs_q [vpu_pkg::NrVRegs][vpu_pkg::ElemsPerLane];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < vpu_pkg::NrVRegs; r++) begin
        for (int e = 0; e < vpu_pkg::ElemsPerLane; e++) begin
          regs_q[r][e] <= '0;
        end
      end
    end else if (wr_en_i) begin
      regs_q[wr_reg_i][wr_row_i] <= wr_data_i;
    end
  end

  assign rd_a_o = regs_q[rd_a_reg_i][rd_row_i];
  assign rd_b_o = regs_q[rd_b_reg_i][rd_row_i];

endmodule : vpu_vrf

`default_nettype wire

// File: logic/vpu_insn_queue.sv
// Relies on the host credit count: a push into a full queue is not detected and overwrites
`default_nettype none

module vpu_insn_queue (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  vpu_pkg::vpu_req_t  req_i,
  input  logic               req_valid_i,
  input  logic               pop_i,
  output vpu_pkg::vpu_req_t  head_o,
  output logic               not_empty_o,
  output logic               req_credit_o
);

  vpu_pkg::vpu_req_t                        mem_q [vpu_pkg::QueueDepth];
  logic [vpu_pkg::QueuePtrWidth-1:0]        wr_ptr_q;
  logic [vpu_pkg::QueuePtrWidth-1:0]        rd_ptr_q;
  logic [vpu_pkg::QueueCntWidth-1:0]        count_q;

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  // Pointers, occupancy and the returned credit
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      req_credit_o <= 1'b0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      unique case ({req_valid_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // One credit back per freed slot
      req_credit_o <= pop_i;
    end
  end

  assign head_o      = mem_q[rd_ptr_q];
  assign not_empty_o = (count_q != '0);

endmodule : vpu_insn_queue

`default_nettype wire

// File: logic/vpu_reduction.sv
// resp_o holds its value until the next instruction completes; sample it with resp_valid_o
`default_nettype none

module vpu_reduction (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  vpu_pkg::lane_cmd_t                       cmd_i,
  input  vpu_pkg::elem_t [vpu_pkg::NrLanes-1:0]    partials_i,
  output vpu_pkg::vpu_resp_t                       resp_o
);

  vpu_pkg::vpu_op_e   op_q;
  logic               pending_q;
  vpu_pkg::elem_t     lane_sum;
  vpu_pkg::vpu_resp_t resp_q;

  // Track the instruction whose last row just went out
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_q      <= vpu_pkg::OP_VMV_VX;
      pending_q <= 1'b0;
    end else begin
      pending_q <= cmd_i.valid && cmd_i.last;
      if (cmd_i.valid && cmd_i.last) begin
        op_q <= cmd_i.op;
      end
    end
  end

  // Wraps modulo 2**ElemWidth
  always_comb begin
    lane_sum = '0;
    for (int l = 0; l < vpu_pkg::NrLanes; l++) begin
      lane_sum = lane_sum + partials_i[l];
    end
  end

  //////////////////////////////
  // Scalar result
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (pending_q) begin
      unique case (op_q)
        vpu_pkg::OP_VREDSUM: resp_q.result <= lane_sum;
        // Element 0 always sits in lane 0, row 0
        vpu_pkg::OP_VMV_XS:  resp_q.result <= partials_i[0];
        default:             resp_q.result <= '0;
      endcase
    end
  end

  assign resp_o = resp_q;

endmodule : vpu_reduction

`default_nettype wire

// File: logic/vpu_sequencer.sv
// One instruction in flight at a time; a pop needs both a queued entry and a response credit
`default_nettype none

module vpu_sequencer (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  vpu_pkg::vpu_req_t  head_i,
  input  logic               not_empty_i,
  output logic               pop_o,
  input  logic               resp_credit_i,
  output vpu_pkg::lane_cmd_t cmd_o,
  output logic               result_valid_o
);

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    REDUCE,
    RESPOND
  } seq_state_e;

  seq_state_e                          state_q;
  vpu_pkg::lane_cmd_t                  cmd_q;
  logic [vpu_pkg::CreditWidth-1:0]     credits_q;
  logic                                can_issue;

  //////////////////////////////
  // Issue decision
  //////////////////////////////

  // The response cycle also frees the datapath
  assign can_issue = (state_q == IDLE) || (state_q == RESPOND);
  assign pop_o     = can_issue && not_empty_i && (credits_q != '0);

  // Response slots granted by the host
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credits_q <= '0;
    end else begin
      unique case ({resp_credit_i, pop_o})
        2'b10:   credits_q <= credits_q + 1'b1;
        2'b01:   credits_q <= credits_q - 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  //////////////////////////////
  // Row FSM
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      cmd_q   <= '0;
    end else begin
      unique case (state_q)
        IDLE, RESPOND: begin
          if (pop_o) begin
            // Latch the head and start at row 0
            cmd_q.op     <= head_i.op;
            cmd_q.vd     <= head_i.vd;
            cmd_q.vs1    <= head_i.vs1;
            cmd_q.vs2    <= head_i.vs2;
            cmd_q.scalar <= head_i.scalar;
            cmd_q.row    <= '0;
            cmd_q.valid  <= 1'b1;
            cmd_q.last   <= 1'b0;
            state_q      <= EXEC;
          end else begin
            state_q <= IDLE;
          end
        end
        EXEC: begin
          if (cmd_q.last) begin
            cmd_q.valid <= 1'b0;
            cmd_q.last  <= 1'b0;
            state_q     <= REDUCE;
          end else begin
            cmd_q.row  <= cmd_q.row + 1'b1;
            cmd_q.last <= (cmd_q.row == vpu_pkg::row_idx_t'(vpu_pkg::ElemsPerLane - 2));
          end
        end
        // Reduction unit registers its result here
        REDUCE: state_q <= RESPOND;
        default: state_q <= IDLE;
      endcase
    end
  end

  assign cmd_o          = cmd_q;
  assign result_valid_o = (state_q == RESPOND);

endmodule : vpu_sequencer

`default_nettype wire

// File: logic/vpu_top.sv
// Host must start with QueueDepth request credits and zero response credits granted
`default_nettype none

module vpu_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  vpu_pkg::vpu_req_t  req_i,
  input  logic               req_valid_i,
  output logic               req_credit_o,
  output vpu_pkg::vpu_resp_t resp_o,
  output logic               resp_valid_o,
  input  logic               resp_credit_i
);

  //////////////////////////////
  // Queue and control
  //////////////////////////////

  vpu_pkg::vpu_req_t  head;
  logic               not_empty;
  logic               pop;
  vpu_pkg::lane_cmd_t cmd;

  vpu_insn_queue i_queue (
    .clk_i        (clk_i        ),
    .arst_n_i     (arst_n_i     ),
    .req_i        (req_i        ),
    .req_valid_i  (req_valid_i  ),
    .pop_i        (pop          ),
    .head_o       (head         ),
    .not_empty_o  (not_empty    ),
    .req_credit_o (req_credit_o )
  );

  vpu_sequencer i_sequencer (
    .clk_i          (clk_i         ),
    .arst_n_i       (arst_n_i      ),
    .head_i         (head          ),
    .not_empty_i    (not_empty     ),
    .pop_o          (pop           ),
    .resp_credit_i  (resp_credit_i ),
    .cmd_o          (cmd           ),
    .result_valid_o (resp_valid_o  )
  );

  //////////////////////////////
  // Lanes and reduction
  //////////////////////////////

  vpu_pkg::elem_t [vpu_pkg::NrLanes-1:0] partials;

  for (genvar l = 0; l < vpu_pkg::NrLanes; l++) begin : gen_lanes
    vpu_lane #(
      .LaneId (l)
    ) i_lane (
      .clk_i     (clk_i       ),
      .arst_n_i  (arst_n_i    ),
      .cmd_i     (cmd         ),
      .partial_o (partials[l] )
    );
  end : gen_lanes

  vpu_reduction i_reduction (
    .clk_i      (clk_i    ),
    .arst_n_i   (arst_n_i ),
    .cmd_i      (cmd      ),
    .partials_i (partials ),
    .resp_o     (resp_o   )
  );

endmodule : vpu_top

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds and runs the vector coprocessor testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f src.f --top-module vpu_tb \
  -Mdir obj_dir -o vpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/vpu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation run returned an error status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1

// File: src.f
common/vpu_pkg.sv
logic/vpu_insn_queue.sv
logic/vpu_sequencer.sv
lane/vpu_vrf.sv
lane/vpu_lane.sv
logic/vpu_reduction.sv
logic/vpu_top.sv
bench/vpu_clkgen.sv
bench/vpu_tb.sv
